// File: Makefile
# Verilator build and simulation of the pdp-11 execute stage
# any variable can be overridden, e.g. make run LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_pdp11_exec
FILELIST  ?= pdp11_exec.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator's exit code is lost in the pipe, the log decides
run: compile
	rm -f $(LOG)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: branch_unit.sv
// pdp-11 branch unit
// forms the branch or jmp target and tests the branch condition
// against the current condition codes

`timescale 1ns/100ps

module branch_unit (
   input  pdp11_exec_pkg::br_cond_t br_cond,
   input  pdp11_exec_pkg::word_t    pc,
   input  pdp11_exec_pkg::word_t    dd_ea,
   input  logic [7:0]               offset,
   input  pdp11_exec_pkg::cc_t      cc,
   output pdp11_exec_pkg::word_t    target,
   output logic                     take
);

   pdp11_exec_pkg::word_t br_target;
   logic                  ge;

   // word offset, sign extended and doubled
   assign br_target = pc + {{7{offset[7]}}, offset, 1'b0};

   assign ge = ~(cc.n ^ cc.v);

   always_comb
   begin
      case (br_cond)
         pdp11_exec_pkg::br_always: take = 1'b1;
         pdp11_exec_pkg::br_jump:   take = 1'b1;
         pdp11_exec_pkg::br_ne:     take = ~cc.z;
         pdp11_exec_pkg::br_eq:     take = cc.z;
         pdp11_exec_pkg::br_ge:     take = ge;
         pdp11_exec_pkg::br_lt:     take = ~ge;
         pdp11_exec_pkg::br_gt:     take = ~cc.z & ge;
         pdp11_exec_pkg::br_le:     take = cc.z | ~ge;
         pdp11_exec_pkg::br_pl:     take = ~cc.n;
         pdp11_exec_pkg::br_mi:     take = cc.n;
         pdp11_exec_pkg::br_hi:     take = ~(cc.c | cc.z);
         pdp11_exec_pkg::br_los:    take = cc.c | cc.z;
         pdp11_exec_pkg::br_vc:     take = ~cc.v;
         pdp11_exec_pkg::br_vs:     take = cc.v;
         pdp11_exec_pkg::br_cc:     take = ~cc.c;
         pdp11_exec_pkg::br_cs:     take = cc.c;
         default:                   take = 1'b0;
      endcase
   end

   always_comb
   begin
      if (br_cond == pdp11_exec_pkg::br_never)
         target = 16'd0;
      else if (br_cond == pdp11_exec_pkg::br_jump)
         target = dd_ea;
      else
         target = br_target;
   end

endmodule

// File: exec_alu.sv
// pdp-11 word alu
// result word and new condition codes for the data and
// condition-code operations

`timescale 1ns/100ps

module exec_alu (
   input  pdp11_exec_pkg::alu_op_t alu_op,
   input  logic [3:0]              cc_mask,
   input  pdp11_exec_pkg::word_t   ss_data,
   input  pdp11_exec_pkg::word_t   dd_data,
   input  pdp11_exec_pkg::cc_t     cc,
   output pdp11_exec_pkg::word_t   alu_result,
   output pdp11_exec_pkg::cc_t     alu_cc,
   output logic                    alu_latch_cc
);

   pdp11_exec_pkg::word_t res;
   pdp11_exec_pkg::cc_t   ncc;
   logic [16:0]           sum;
   logic                  res_n;
   logic                  res_z;
   logic                  nz_from_res;

   // add needs the carry out of bit 15
   assign sum = {1'b0, ss_data} + {1'b0, dd_data};

   always_comb
   begin
      case (alu_op)
         pdp11_exec_pkg::alu_mov:  res = ss_data;
         pdp11_exec_pkg::alu_cmp:  res = ss_data - dd_data;
         pdp11_exec_pkg::alu_bit:  res = ss_data & dd_data;
         pdp11_exec_pkg::alu_bic:  res = ~ss_data & dd_data;
         pdp11_exec_pkg::alu_bis:  res = ss_data | dd_data;
         pdp11_exec_pkg::alu_add:  res = sum[15:0];
         pdp11_exec_pkg::alu_sub:  res = dd_data - ss_data;
         pdp11_exec_pkg::alu_xor:  res = ss_data ^ dd_data;
         pdp11_exec_pkg::alu_com:  res = ~dd_data;
         pdp11_exec_pkg::alu_inc:  res = dd_data + 16'd1;
         pdp11_exec_pkg::alu_dec:  res = dd_data - 16'd1;
         pdp11_exec_pkg::alu_neg:  res = 16'd0 - dd_data;
         pdp11_exec_pkg::alu_adc:  res = dd_data + {15'd0, cc.c};
         pdp11_exec_pkg::alu_sbc:  res = dd_data - {15'd0, cc.c};
         pdp11_exec_pkg::alu_tst:  res = dd_data;
         pdp11_exec_pkg::alu_ror:  res = {cc.c, dd_data[15:1]};
         pdp11_exec_pkg::alu_rol:  res = {dd_data[14:0], cc.c};
         pdp11_exec_pkg::alu_asr:  res = {dd_data[15], dd_data[15:1]};
         pdp11_exec_pkg::alu_asl:  res = {dd_data[14:0], 1'b0};
         pdp11_exec_pkg::alu_swab: res = {dd_data[7:0], dd_data[15:8]};
         pdp11_exec_pkg::alu_sxt:  res = {16{cc.n}};
         default:                  res = 16'd0;
      endcase
   end

   assign res_n = res[15];
   assign res_z = (res == 16'd0);

   // these set n and z their own way or not at all
   assign nz_from_res = !(alu_op inside {pdp11_exec_pkg::alu_none,
                                         pdp11_exec_pkg::alu_clr,
                                         pdp11_exec_pkg::alu_swab,
                                         pdp11_exec_pkg::alu_sxt,
                                         pdp11_exec_pkg::alu_clear_cc,
                                         pdp11_exec_pkg::alu_set_cc});

   always_comb
   begin
      ncc = cc;
      if (nz_from_res)
      begin
         ncc.n = res_n;
         ncc.z = res_z;
      end

      case (alu_op)
         pdp11_exec_pkg::alu_mov, pdp11_exec_pkg::alu_bit, pdp11_exec_pkg::alu_bic,
         pdp11_exec_pkg::alu_bis, pdp11_exec_pkg::alu_xor:
            ncc.v = 1'b0;
         pdp11_exec_pkg::alu_tst:
         begin
            ncc.v = 1'b0;
            ncc.c = 1'b0;
         end
         pdp11_exec_pkg::alu_com:
         begin
            ncc.v = 1'b0;
            ncc.c = 1'b1;
         end
         pdp11_exec_pkg::alu_add:
         begin
            ncc.v = (ss_data[15] == dd_data[15]) && (res_n != ss_data[15]);
            ncc.c = sum[16];
         end
         pdp11_exec_pkg::alu_cmp:
         begin
            ncc.v = (ss_data[15] ^ dd_data[15]) & (res_n ^ ss_data[15]);
            ncc.c = ss_data < dd_data;
         end
         pdp11_exec_pkg::alu_sub:
         begin
            ncc.v = (ss_data[15] ^ dd_data[15]) & (res_n ^ dd_data[15]);
            ncc.c = dd_data < ss_data;
         end
         pdp11_exec_pkg::alu_inc:
            ncc.v = (res == 16'o100000);
         pdp11_exec_pkg::alu_dec:
            ncc.v = (res == 16'o077777);
         pdp11_exec_pkg::alu_neg:
         begin
            ncc.v = (res == 16'o100000);
            ncc.c = ~res_z;
         end
         pdp11_exec_pkg::alu_adc:
         begin
            ncc.v = (res == 16'o100000);
            ncc.c = cc.c & res_z;
         end
         pdp11_exec_pkg::alu_sbc:
         begin
            ncc.v = (res == 16'o077777);
            ncc.c = cc.c & (res == 16'o177777);
         end
         // c is the bit shifted out, v is n xor c
         pdp11_exec_pkg::alu_ror, pdp11_exec_pkg::alu_asr:
         begin
            ncc.c = dd_data[0];
            ncc.v = res_n ^ dd_data[0];
         end
         pdp11_exec_pkg::alu_rol, pdp11_exec_pkg::alu_asl:
         begin
            ncc.c = dd_data[15];
            ncc.v = res_n ^ dd_data[15];
         end
         pdp11_exec_pkg::alu_swab:
            ncc = '{n: res[7], z: (res[7:0] == 8'd0), v: 1'b0, c: 1'b0};
         pdp11_exec_pkg::alu_sxt:
         begin
            ncc.z = ~cc.n;
            ncc.v = 1'b0;
         end
         pdp11_exec_pkg::alu_clr:
            ncc = '{n: 1'b0, z: 1'b1, v: 1'b0, c: 1'b0};
         pdp11_exec_pkg::alu_clear_cc:
            ncc = pdp11_exec_pkg::cc_t'(cc & ~cc_mask);
         pdp11_exec_pkg::alu_set_cc:
            ncc = pdp11_exec_pkg::cc_t'(cc | cc_mask);
         default:
         begin
         end
      endcase
   end

   assign alu_result   = res;
   assign alu_cc       = ncc;
   assign alu_latch_cc = (alu_op != pdp11_exec_pkg::alu_none);

endmodule

// File: exec_golden.txt
# isn pc ss_data dd_data dd_ea cc | e1_result new_cc latch_cc new_pc latch_pc
# all octal, cc and new_cc as nzvc
060203 001000 177777 000001 000000 00 000000 05 1 000000 0
060203 001000 077777 000001 000000 00 100000 12 1 000000 0
160203 001000 000100 000100 000000 00 000000 04 1 000000 0
160203 001000 000200 000100 000000 00 177700 11 1 000000 0
160203 001000 000003 000010 000000 17 000005 00 1 000000 0
160203 001000 000001 100000 000000 00 077777 02 1 000000 0
020203 001000 001234 001234 000000 00 000000 04 1 000000 0
020203 001000 000001 000002 000000 00 177777 11 1 000000 0
020203 001000 000007 000002 000000 17 000005 00 1 000000 0
010203 001000 100000 000000 000000 03 100000 11 1 000000 0
030203 001000 170000 007777 000000 13 000000 05 1 000000 0
040203 001000 000017 177777 000000 01 177760 11 1 000000 0
050203 001000 100000 000001 000000 00 100001 10 1 000000 0
074203 001000 125252 052525 000000 02 177777 10 1 000000 0
005403 001000 000000 100000 000000 00 100000 13 1 000000 0
005403 001000 000000 000000 000000 17 000000 04 1 000000 0
005203 001000 000000 077777 000000 01 100000 13 1 000000 0
005203 001000 000000 177777 000000 00 000000 04 1 000000 0
005303 001000 000000 100000 000000 01 077777 03 1 000000 0
005303 001000 000000 000000 000000 00 177777 10 1 000000 0
005503 001000 000000 177777 000000 01 000000 05 1 000000 0
005503 001000 000000 077777 000000 01 100000 12 1 000000 0
005603 001000 000000 000000 000000 01 177777 11 1 000000 0
005603 001000 000000 100000 000000 01 077777 02 1 000000 0
006003 001000 000000 000001 000000 01 100000 11 1 000000 0
006103 001000 000000 100000 000000 00 000000 07 1 000000 0
006203 001000 000000 100001 000000 00 140000 11 1 000000 0
006303 001000 000000 040000 000000 01 100000 12 1 000000 0
000303 001000 000000 000377 000000 17 177400 04 1 000000 0
006703 001000 000000 000000 000000 13 177777 11 1 000000 0
006703 001000 000000 000000 000000 06 000000 04 1 000000 0
005003 001000 000000 123456 000000 17 000000 04 1 000000 0
005103 001000 000000 000000 000000 00 177777 11 1 000000 0
005703 001000 000000 000000 000000 13 000000 04 1 000000 0
000251 001000 000000 000000 000000 17 000000 06 1 000000 0
000266 001000 000000 000000 000000 01 000000 07 1 000000 0
000240 001000 000000 000000 000000 12 000000 12 1 000000 0
000777 001000 000000 000000 000000 00 000000 00 0 000776 1
001010 001000 000000 000000 000000 00 000000 00 0 001020 1
001370 001000 000000 000000 000000 04 000000 04 0 000760 0
001770 001000 000000 000000 000000 04 000000 04 0 000760 1
001410 001000 000000 000000 000000 00 000000 00 0 001020 0
002010 001000 000000 000000 000000 12 000000 12 0 001020 1
002370 001000 000000 000000 000000 10 000000 10 0 000760 0
002770 001000 000000 000000 000000 02 000000 02 0 000760 1
002410 001000 000000 000000 000000 00 000000 00 0 001020 0
003010 001000 000000 000000 000000 00 000000 00 0 001020 1
003370 001000 000000 000000 000000 04 000000 04 0 000760 0
003770 001000 000000 000000 000000 04 000000 04 0 000760 1
003410 001000 000000 000000 000000 12 000000 12 0 001020 0
100010 001000 000000 000000 000000 00 000000 00 0 001020 1
100370 001000 000000 000000 000000 10 000000 10 0 000760 0
100770 001000 000000 000000 000000 10 000000 10 0 000760 1
100410 001000 000000 000000 000000 00 000000 00 0 001020 0
101010 001000 000000 000000 000000 00 000000 00 0 001020 1
101370 001000 000000 000000 000000 01 000000 01 0 000760 0
101770 001000 000000 000000 000000 04 000000 04 0 000760 1
101410 001000 000000 000000 000000 00 000000 00 0 001020 0
102010 001000 000000 000000 000000 00 000000 00 0 001020 1
102370 001000 000000 000000 000000 02 000000 02 0 000760 0
102770 001000 000000 000000 000000 02 000000 02 0 000760 1
102410 001000 000000 000000 000000 00 000000 00 0 001020 0
103010 001000 000000 000000 000000 00 000000 00 0 001020 1
103370 001000 000000 000000 000000 01 000000 01 0 000760 0
103770 001000 000000 000000 000000 01 000000 01 0 000760 1
103410 001000 000000 000000 000000 00 000000 00 0 001020 0
000113 001000 000000 000000 002460 04 000000 04 0 002460 1
000103 001000 000000 000000 002460 04 000000 04 0 000000 0
070203 001000 000012 000034 000000 05 000000 05 0 000000 0
105003 001000 000000 000077 000000 12 000000 12 0 000000 0

// File: exec_result_reg.sv
// execute stage output register
// holds result, codes, pc and their strobes for one cycle;
// a cycle without enable presents zeros and low strobes

`timescale 1ns/100ps

module exec_result_reg (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  enable,
   input  pdp11_exec_pkg::word_t alu_result,
   input  pdp11_exec_pkg::word_t target,
   input  pdp11_exec_pkg::cc_t   alu_cc,
   input  logic                  alu_latch_cc,
   input  logic                  take,
   output pdp11_exec_pkg::word_t e1_result,
   output pdp11_exec_pkg::word_t new_pc,
   output pdp11_exec_pkg::cc_t   new_cc,
   output logic                  latch_cc,
   output logic                  latch_pc,
   output logic                  done
);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         done      <= 1'b0;
         latch_cc  <= 1'b0;
         latch_pc  <= 1'b0;
         e1_result <= 16'd0;
         new_pc    <= 16'd0;
         new_cc    <= '0;
      end
      else
      begin
         done      <= enable;
         latch_cc  <= enable & alu_latch_cc;
         latch_pc  <= enable & take;
         e1_result <= enable ? alu_result : 16'd0;
         new_pc    <= enable ? target : 16'd0;
         new_cc    <= enable ? alu_cc : '0;
      end
   end

endmodule

// File: isn_decode.sv
// pdp-11 instruction decoder
// maps an instruction word onto an alu operation, a branch condition
// and the condition-code mask of the clear/set instructions

`timescale 1ns/100ps

module isn_decode (
   input  pdp11_exec_pkg::word_t    isn,
   output pdp11_exec_pkg::alu_op_t  alu_op,
   output pdp11_exec_pkg::br_cond_t br_cond,
   output logic [3:0]               cc_mask
);

   // sel is {isn[15], isn[10:8]} of a branch instruction
   function automatic pdp11_exec_pkg::br_cond_t branch_cond(input logic [3:0] sel);
      pdp11_exec_pkg::br_cond_t cond;
      case (sel)
         4'b0001: cond = pdp11_exec_pkg::br_always;
         4'b0010: cond = pdp11_exec_pkg::br_ne;
         4'b0011: cond = pdp11_exec_pkg::br_eq;
         4'b0100: cond = pdp11_exec_pkg::br_ge;
         4'b0101: cond = pdp11_exec_pkg::br_lt;
         4'b0110: cond = pdp11_exec_pkg::br_gt;
         4'b0111: cond = pdp11_exec_pkg::br_le;
         4'b1000: cond = pdp11_exec_pkg::br_pl;
         4'b1001: cond = pdp11_exec_pkg::br_mi;
         4'b1010: cond = pdp11_exec_pkg::br_hi;
         4'b1011: cond = pdp11_exec_pkg::br_los;
         4'b1100: cond = pdp11_exec_pkg::br_vc;
         4'b1101: cond = pdp11_exec_pkg::br_vs;
         4'b1110: cond = pdp11_exec_pkg::br_cc;
         4'b1111: cond = pdp11_exec_pkg::br_cs;
         default: cond = pdp11_exec_pkg::br_never;
      endcase
      return cond;
   endfunction

   always_comb
   begin
      alu_op  = pdp11_exec_pkg::alu_none;
      br_cond = pdp11_exec_pkg::br_never;
      cc_mask = 4'b0000;

      case (isn[15:12])
         pdp11_exec_pkg::op_single_group:
            case (isn[11:6])
               pdp11_exec_pkg::op_jmp:
                  // jmp to a register is illegal, never latched
                  if (isn[5:3] != 3'b000)
                     br_cond = pdp11_exec_pkg::br_jump;
               pdp11_exec_pkg::op_ccop:
                  if (isn[5])
                  begin
                     alu_op  = isn[4] ? pdp11_exec_pkg::alu_set_cc :
                                        pdp11_exec_pkg::alu_clear_cc;
                     cc_mask = isn[3:0];
                  end
               pdp11_exec_pkg::op_swab_lo: alu_op = pdp11_exec_pkg::alu_swab;
               6'o50: alu_op = pdp11_exec_pkg::alu_clr;
               6'o51: alu_op = pdp11_exec_pkg::alu_com;
               6'o52: alu_op = pdp11_exec_pkg::alu_inc;
               6'o53: alu_op = pdp11_exec_pkg::alu_dec;
               6'o54: alu_op = pdp11_exec_pkg::alu_neg;
               6'o55: alu_op = pdp11_exec_pkg::alu_adc;
               6'o56: alu_op = pdp11_exec_pkg::alu_sbc;
               6'o57: alu_op = pdp11_exec_pkg::alu_tst;
               6'o60: alu_op = pdp11_exec_pkg::alu_ror;
               6'o61: alu_op = pdp11_exec_pkg::alu_rol;
               6'o62: alu_op = pdp11_exec_pkg::alu_asr;
               6'o63: alu_op = pdp11_exec_pkg::alu_asl;
               6'o67: alu_op = pdp11_exec_pkg::alu_sxt;
               default:
                  // br .. ble live in 0004xx-0037xx
                  if (!isn[11])
                     br_cond = branch_cond({1'b0, isn[10:8]});
            endcase
         pdp11_exec_pkg::op_byte_group:
            // bpl .. bcs, the byte forms are not handled
            if (!isn[11])
               br_cond = branch_cond({1'b1, isn[10:8]});
         pdp11_exec_pkg::op_eis_group:
            if (isn[11:9] == pdp11_exec_pkg::op_xor)
               alu_op = pdp11_exec_pkg::alu_xor;
         pdp11_exec_pkg::op_mov: alu_op = pdp11_exec_pkg::alu_mov;
         pdp11_exec_pkg::op_cmp: alu_op = pdp11_exec_pkg::alu_cmp;
         pdp11_exec_pkg::op_bit: alu_op = pdp11_exec_pkg::alu_bit;
         pdp11_exec_pkg::op_bic: alu_op = pdp11_exec_pkg::alu_bic;
         pdp11_exec_pkg::op_bis: alu_op = pdp11_exec_pkg::alu_bis;
         pdp11_exec_pkg::op_add: alu_op = pdp11_exec_pkg::alu_add;
         pdp11_exec_pkg::op_sub: alu_op = pdp11_exec_pkg::alu_sub;
         default:
         begin
         end
      endcase
   end

endmodule

// File: pdp11_exec.f
pdp11_exec_pkg.sv
isn_decode.sv
exec_alu.sv
branch_unit.sv
exec_result_reg.sv
pdp11_exec.sv
tb_pdp11_exec.sv

// File: pdp11_exec.sv
// pdp-11 word execute stage
// decode, alu and branch logic followed by one output register,
// one instruction per cycle with a fixed latency of one clock

`timescale 1ns/100ps

module pdp11_exec (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  enable,
   input  pdp11_exec_pkg::word_t isn,
   input  pdp11_exec_pkg::word_t pc,
   input  pdp11_exec_pkg::word_t ss_data,
   input  pdp11_exec_pkg::word_t dd_data,
   input  pdp11_exec_pkg::word_t dd_ea,
   input  pdp11_exec_pkg::cc_t   cc,
   output pdp11_exec_pkg::word_t e1_result,
   output pdp11_exec_pkg::cc_t   new_cc,
   output logic                  latch_cc,
   output pdp11_exec_pkg::word_t new_pc,
   output logic                  latch_pc,
   output logic                  done
);

   pdp11_exec_pkg::alu_op_t  alu_op;
   pdp11_exec_pkg::br_cond_t br_cond;
   logic [3:0]               cc_mask;
   pdp11_exec_pkg::word_t    alu_result;
   pdp11_exec_pkg::cc_t      alu_cc;
   logic                     alu_latch_cc;
   pdp11_exec_pkg::word_t    target;
   logic                     take;

   isn_decode u_decode (
      .isn     (isn),
      .alu_op  (alu_op),
      .br_cond (br_cond),
      .cc_mask (cc_mask)
   );

   exec_alu u_alu (
      .alu_op       (alu_op),
      .cc_mask      (cc_mask),
      .ss_data      (ss_data),
      .dd_data      (dd_data),
      .cc           (cc),
      .alu_result   (alu_result),
      .alu_cc       (alu_cc),
      .alu_latch_cc (alu_latch_cc)
   );

   // branch offset is the low byte of the instruction
   branch_unit u_branch (
      .br_cond (br_cond),
      .pc      (pc),
      .dd_ea   (dd_ea),
      .offset  (isn[7:0]),
      .cc      (cc),
      .target  (target),
      .take    (take)
   );

   exec_result_reg u_out (
      .clk          (clk),
      .rst          (rst),
      .enable       (enable),
      .alu_result   (alu_result),
      .target       (target),
      .alu_cc       (alu_cc),
      .alu_latch_cc (alu_latch_cc),
      .take         (take),
      .e1_result    (e1_result),
      .new_pc       (new_pc),
      .new_cc       (new_cc),
      .latch_cc     (latch_cc),
      .latch_pc     (latch_pc),
      .done         (done)
   );

endmodule

// File: pdp11_exec_pkg.sv
// pdp-11 execute stage shared definitions
// machine word, condition codes, decoded operation and branch types,
// and the instruction field values used by the decoder

package pdp11_exec_pkg;

   typedef logic [15:0] word_t;

   // ordered n, z, v, c so a 4-bit mask lines up with isn[3:0]
   typedef struct packed {
      logic n;
      logic z;
      logic v;
      logic c;
   } cc_t;

   typedef enum logic [4:0] {
      alu_none,
      alu_mov,
      alu_cmp,
      alu_bit,
      alu_bic,
      alu_bis,
      alu_add,
      alu_sub,
      alu_xor,
      alu_clr,
      alu_com,
      alu_inc,
      alu_dec,
      alu_neg,
      alu_adc,
      alu_sbc,
      alu_tst,
      alu_ror,
      alu_rol,
      alu_asr,
      alu_asl,
      alu_swab,
      alu_sxt,
      alu_clear_cc,
      alu_set_cc
   } alu_op_t;

   typedef enum logic [4:0] {
      br_never,
      br_always,
      br_jump,
      br_ne,
      br_eq,
      br_ge,
      br_lt,
      br_gt,
      br_le,
      br_pl,
      br_mi,
      br_hi,
      br_los,
      br_vc,
      br_vs,
      br_cc,
      br_cs
   } br_cond_t;

   // isn[15:12] groups
   localparam logic [3:0] op_single_group = 4'o00;
   localparam logic [3:0] op_eis_group    = 4'o07;
   localparam logic [3:0] op_byte_group   = 4'o10;

   // double-operand nibbles, word forms only
   localparam logic [3:0] op_mov = 4'o01;
   localparam logic [3:0] op_cmp = 4'o02;
   localparam logic [3:0] op_bit = 4'o03;
   localparam logic [3:0] op_bic = 4'o04;
   localparam logic [3:0] op_bis = 4'o05;
   localparam logic [3:0] op_add = 4'o06;
   localparam logic [3:0] op_sub = 4'o16;

   // isn[11:9] inside the eis group
   localparam logic [2:0] op_xor = 3'o4;

   // isn[11:6] inside the single-operand group
   localparam logic [5:0] op_jmp     = 6'o01;
   localparam logic [5:0] op_ccop    = 6'o02;
   localparam logic [5:0] op_swab_lo = 6'o03;

endpackage

// File: tb_pdp11_exec.sv
// testbench for the pdp-11 word execute stage
// replays golden vectors one per cycle, with a few idle gaps,
// and checks every output one clock after each issue

`timescale 1ns/100ps

module tb_pdp11_exec;

   typedef struct packed {
      pdp11_exec_pkg::word_t isn;
      pdp11_exec_pkg::word_t pc;
      pdp11_exec_pkg::word_t ss;
      pdp11_exec_pkg::word_t dd;
      pdp11_exec_pkg::word_t ea;
      pdp11_exec_pkg::cc_t   cc;
      pdp11_exec_pkg::word_t res;
      pdp11_exec_pkg::cc_t   ncc;
      logic                  lcc;
      pdp11_exec_pkg::word_t npc;
      logic                  lpc;
   } vec_t;

   logic                  clk;
   logic                  rst;
   logic                  enable;
   pdp11_exec_pkg::word_t isn;
   pdp11_exec_pkg::word_t pc;
   pdp11_exec_pkg::word_t ss_data;
   pdp11_exec_pkg::word_t dd_data;
   pdp11_exec_pkg::word_t dd_ea;
   pdp11_exec_pkg::cc_t   cc;
   pdp11_exec_pkg::word_t e1_result;
   pdp11_exec_pkg::cc_t   new_cc;
   logic                  latch_cc;
   pdp11_exec_pkg::word_t new_pc;
   logic                  latch_pc;
   logic                  done;

   vec_t vecs[$];
   int   cycle_count    = 0;
   int   cycle_limit    = 0;

   pdp11_exec DUT (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .isn       (isn),
      .pc        (pc),
      .ss_data   (ss_data),
      .dd_data   (dd_data),
      .dd_ea     (dd_ea),
      .cc        (cc),
      .e1_result (e1_result),
      .new_cc    (new_cc),
      .latch_cc  (latch_cc),
      .new_pc    (new_pc),
      .latch_pc  (latch_pc),
      .done      (done)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // watchdog whose limit is set once the vectors are loaded
   initial
   begin
      forever
      begin
         @(posedge clk);
         cycle_count++;
         if (cycle_limit > 0 && cycle_count >= cycle_limit)
         begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            abort_run();
         end
      end
   end

   task automatic abort_run();
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input pdp11_exec_pkg::word_t got,
                             input pdp11_exec_pkg::word_t exp, input string what);
      if (got !== exp)
      begin
         $display("MISMATCH at time %0t: %s is %06o, expected %06o", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_cc(input pdp11_exec_pkg::cc_t got,
                           input pdp11_exec_pkg::cc_t exp, input string what);
      if (got !== exp)
      begin
         $display("MISMATCH at time %0t: %s nzvc is %b, expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         $display("MISMATCH at time %0t: %s is %b, expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   // a disabled cycle gives zeros and low strobes
   task automatic check_idle(input string when);
      check_flag(done, 1'b0, {when, " done"});
      check_flag(latch_cc, 1'b0, {when, " latch_cc"});
      check_flag(latch_pc, 1'b0, {when, " latch_pc"});
      check_word(e1_result, 16'd0, {when, " e1_result"});
      check_word(new_pc, 16'd0, {when, " new_pc"});
      check_cc(new_cc, 4'd0, {when, " new_cc"});
   endtask

   task automatic check_outputs(input vec_t v, input int idx);
      string tag;
      tag = $sformatf("vector %0d (isn %06o)", idx, v.isn);
      check_flag(done, 1'b1, {tag, " done"});
      check_word(e1_result, v.res, {tag, " e1_result"});
      check_cc(new_cc, v.ncc, {tag, " new_cc"});
      check_flag(latch_cc, v.lcc, {tag, " latch_cc"});
      check_word(new_pc, v.npc, {tag, " new_pc"});
      check_flag(latch_pc, v.lpc, {tag, " latch_pc"});
   endtask

   task automatic apply_vector(input vec_t v);
      enable  = 1'b1;
      isn     = v.isn;
      pc      = v.pc;
      ss_data = v.ss;
      dd_data = v.dd;
      dd_ea   = v.ea;
      cc      = v.cc;
   endtask

   initial
   begin
      int          fd;
      int          n;
      int          gap;
      string       line;
      logic [15:0] f [0:10];
      vec_t        v;

      rst     = 1'b1;
      enable  = 1'b0;
      isn     = 16'd0;
      pc      = 16'd0;
      ss_data = 16'd0;
      dd_data = 16'd0;
      dd_ea   = 16'd0;
      cc      = 4'd0;
      // fixed seed for the idle gap lengths
      void'($urandom(64020));

      fd = $fopen("exec_golden.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the golden vector file exec_golden.txt");
         abort_run();
      end
      while (!$feof(fd))
      begin
         line = "";
         if ($fgets(line, fd) == 0)
            break;
         n = $sscanf(line, "%o %o %o %o %o %o %o %o %o %o %o", f[0], f[1], f[2], f[3],
                     f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
         if (n == 11)
         begin
            v = '{f[0], f[1], f[2], f[3], f[4], f[5][3:0], f[6], f[7][3:0], f[8][0],
                  f[9], f[10][0]};
            vecs.push_back(v);
         end
         else if (n > 0)
         begin
            $display("malformed line in the golden vector file: %s", line);
            abort_run();
         end
      end
      $fclose(fd);
      if (vecs.size() == 0)
      begin
         $display("the golden vector file holds no vectors");
         abort_run();
      end
      cycle_limit = 5 + 4 * vecs.size() + 50;

      // reset spans 5 rising edges
      repeat (5) @(posedge clk);
      @(negedge clk);
      check_idle("in reset");
      rst = 1'b0;
      @(negedge clk);
      check_idle("after reset");

      foreach (vecs[i])
      begin
         if (i % 8 == 7)
         begin
            enable = 1'b0;
            gap    = 1 + ($urandom % 3);
            repeat (gap)
            begin
               @(negedge clk);
               check_idle($sformatf("idle before vector %0d", i));
            end
         end
         apply_vector(vecs[i]);
         @(negedge clk);
         check_outputs(vecs[i], i);
      end

      enable = 1'b0;
      @(negedge clk);
      check_idle("after the last vector");

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule
